/* rtl/apb_mult_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_mult_regs (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             psel,
  input  wire                             penable,
  input  wire                             pwrite,
  input  wire  [apb_pkg::APB_ADDR_W-1:0]  paddr,
  input  wire  [apb_pkg::APB_DATA_W-1:0]  pwdata,
  output logic [apb_pkg::APB_DATA_W-1:0]  prdata,
  output logic                            pready,
  output logic                            pslverr,
  output logic                            mul_valid,
  output logic [mult_pkg::OPERAND_W-1:0]  opa,
  output logic [mult_pkg::OPERAND_W-1:0]  opb,
  input  wire                             prod_valid,
  input  wire  [mult_pkg::PROD_W-1:0]     prod
);

  import mult_pkg::*;
  import apb_pkg::*;

  mult_state_t       state;
  mult_cmd_t         cmd;
  logic [PROD_W-1:0] result;
  logic              access;
  logic              wr_en;
  logic              addr_hit;

  assign access = psel & penable;
  assign wr_en  = access & pwrite;

  // No wait states
  assign pready = 1'b1;

  always_comb begin
    prdata   = '0;
    addr_hit = 1'b1;
    case (paddr)
      ADDR_OPA:    prdata[OPERAND_W-1:0] = opa;
      ADDR_OPB:    prdata[OPERAND_W-1:0] = opb;
      ADDR_CTRL:   prdata = '0;
      ADDR_STATUS: begin
        prdata[STATUS_BUSY_BIT] = (state == BUSY);
        prdata[STATUS_DONE_BIT] = (state == DONE);
      end
      ADDR_RESULT: prdata = result;
      default:     addr_hit = 1'b0;
    endcase
  end

  assign pslverr = access & ~addr_hit;

  always_comb begin
    cmd = CMD_NOP;
    if (wr_en && paddr == ADDR_CTRL) begin
      cmd = mult_cmd_t'(pwdata[1:0]);
    end
  end

  // Operand registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      opa <= '0;
      opb <= '0;
    end else begin
      if (wr_en && paddr == ADDR_OPA) begin
        opa <= pwdata[OPERAND_W-1:0];
      end
      if (wr_en && paddr == ADDR_OPB) begin
        opb <= pwdata[OPERAND_W-1:0];
      end
    end
  end

  // Control FSM, commands during BUSY are dropped
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= IDLE;
      mul_valid <= 1'b0;
      result    <= '0;
    end else begin
      mul_valid <= 1'b0;
      case (state)
        IDLE, DONE: begin
          if (cmd == CMD_START) begin
            state     <= BUSY;
            mul_valid <= 1'b1;
          end else if (cmd == CMD_CLEAR) begin
            state <= IDLE;
          end
        end
        BUSY: begin
          if (prod_valid) begin
            state <= DONE;
          end
        end
        default: state <= IDLE;
      endcase
      if (prod_valid) begin
        result <= prod;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/apb_pkg.sv */
`default_nettype none

package apb_pkg;

  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // Register map
  localparam logic [APB_ADDR_W-1:0] ADDR_OPA    = 8'h00;
  localparam logic [APB_ADDR_W-1:0] ADDR_OPB    = 8'h04;
  localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 8'h08;
  localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 8'h0C;
  localparam logic [APB_ADDR_W-1:0] ADDR_RESULT = 8'h10;

  // Written to CTRL[1:0]
  typedef enum logic [1:0] {
    CMD_NOP   = 2'd0,
    CMD_START = 2'd1,
    CMD_CLEAR = 2'd2
  } mult_cmd_t;

  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

endpackage

`default_nettype wire

/* rtl/array_mult8.sv */
`timescale 1ns/1ps
`default_nettype none

module array_mult8 (
  input  wire  [mult_pkg::HALF_W-1:0]      a,
  input  wire  [mult_pkg::HALF_W-1:0]      b,
  output logic [mult_pkg::HALF_PROD_W-1:0] p
);

  import mult_pkg::*;

  // Partial products, one row per bit of a
  logic [HALF_W-1:0] pp [HALF_W];
  // Sum and carry vectors left by each reduction row
  logic [HALF_W-1:0] s  [HALF_W];
  logic [HALF_W-2:0] c  [1:HALF_W-1];
  logic              rc;

  always_comb begin
    for (int i = 0; i < HALF_W; i++) begin
      pp[i] = b & {HALF_W{a[i]}};
    end

    s[0] = pp[0];

    // Half adders in the first row
    for (int j = 0; j < HALF_W-1; j++) begin
      s[1][j] = s[0][j+1] ^ pp[1][j];
      c[1][j] = s[0][j+1] & pp[1][j];
    end
    s[1][HALF_W-1] = pp[1][HALF_W-1];

    // Full adders in the remaining rows
    for (int i = 2; i < HALF_W; i++) begin
      for (int j = 0; j < HALF_W-1; j++) begin
        s[i][j] = s[i-1][j+1] ^ c[i-1][j] ^ pp[i][j];
        c[i][j] = (s[i-1][j+1] & c[i-1][j]) |
                  (pp[i][j] & (s[i-1][j+1] ^ c[i-1][j]));
      end
      s[i][HALF_W-1] = pp[i][HALF_W-1];
    end

    // Low byte falls out of the array one bit per row
    for (int i = 0; i < HALF_W; i++) begin
      p[i] = s[i][0];
    end

    // Final ripple row gives the upper byte
    rc = 1'b0;
    for (int j = 0; j < HALF_W-1; j++) begin
      p[HALF_W+j] = c[HALF_W-1][j] ^ s[HALF_W-1][j+1] ^ rc;
      rc = (c[HALF_W-1][j] & s[HALF_W-1][j+1]) |
           (rc & (c[HALF_W-1][j] ^ s[HALF_W-1][j+1]));
    end
    p[HALF_PROD_W-1] = rc;
  end

endmodule

`default_nettype wire

/* rtl/cla_adder32.sv */
`timescale 1ns/1ps
`default_nettype none

module cla_adder32 (
  input  wire  [mult_pkg::PROD_W-1:0] a,
  input  wire  [mult_pkg::PROD_W-1:0] b,
  output logic [mult_pkg::PROD_W-1:0] sum
);

  import mult_pkg::*;

  logic [PROD_W-1:0]   p;
  logic [PROD_W-1:0]   g;
  logic [PROD_W-1:0]   c;
  logic [PROD_W/4-1:0] gp;
  logic [PROD_W/4-1:0] gg;
  logic [PROD_W/4-1:0] gc;

  // Carry into position pos, as a flat sum of products
  function automatic logic lookahead(input logic [PROD_W/4-1:0] gen,
                                     input logic [PROD_W/4-1:0] prop,
                                     input logic                cin,
                                     input int                  pos);
    logic carry;
    logic term;
    carry = cin;
    for (int n = 0; n < pos; n++) begin
      carry = carry & prop[n];
    end
    for (int m = 0; m < pos; m++) begin
      term = gen[m];
      for (int n = m + 1; n < pos; n++) begin
        term = term & prop[n];
      end
      carry = carry | term;
    end
    return carry;
  endfunction

  assign p = a ^ b;
  assign g = a & b;

  always_comb begin
    // Group propagate and generate
    for (int k = 0; k < PROD_W/4; k++) begin
      gp[k] = &p[4*k +: 4];
      gg[k] = lookahead({{(PROD_W/4-4){1'b0}}, g[4*k +: 4]},
                        {{(PROD_W/4-4){1'b0}}, p[4*k +: 4]}, 1'b0, 4);
    end

    // Second level, adder carry-in tied low
    for (int k = 0; k < PROD_W/4; k++) begin
      gc[k] = lookahead(gg, gp, 1'b0, k);
    end

    for (int k = 0; k < PROD_W/4; k++) begin
      for (int j = 0; j < 4; j++) begin
        c[4*k+j] = lookahead({{(PROD_W/4-4){1'b0}}, g[4*k +: 4]},
                             {{(PROD_W/4-4){1'b0}}, p[4*k +: 4]}, gc[k], j);
      end
    end
  end

  assign sum = p ^ c;

endmodule

`default_nettype wire

/* rtl/mult16_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module mult16_apb (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            psel,
  input  wire                            penable,
  input  wire                            pwrite,
  input  wire  [apb_pkg::APB_ADDR_W-1:0] paddr,
  input  wire  [apb_pkg::APB_DATA_W-1:0] pwdata,
  output logic [apb_pkg::APB_DATA_W-1:0] prdata,
  output logic                           pready,
  output logic                           pslverr
);

  import mult_pkg::*;

  logic                 mul_valid;
  logic [OPERAND_W-1:0] opa;
  logic [OPERAND_W-1:0] opb;
  logic                 prod_valid;
  logic [PROD_W-1:0]    prod;

  apb_mult_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .mul_valid  (mul_valid),
    .opa        (opa),
    .opb        (opb),
    .prod_valid (prod_valid),
    .prod       (prod)
  );

  mult16_datapath u_datapath (
    .clk        (clk),
    .rst_n      (rst_n),
    .mul_valid  (mul_valid),
    .opa        (opa),
    .opb        (opb),
    .prod_valid (prod_valid),
    .prod       (prod)
  );

endmodule

`default_nettype wire

/* rtl/mult16_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module mult16_datapath (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            mul_valid,
  input  wire  [mult_pkg::OPERAND_W-1:0] opa,
  input  wire  [mult_pkg::OPERAND_W-1:0] opb,
  output logic                           prod_valid,
  output logic [mult_pkg::PROD_W-1:0]    prod
);

  import mult_pkg::*;

  logic [HALF_PROD_W-1:0]  p_ll;
  logic [HALF_PROD_W-1:0]  p_hl;
  logic [HALF_PROD_W-1:0]  p_lh;
  logic [HALF_PROD_W-1:0]  p_hh;
  logic [HALF_PROD_W-1:0]  q_ll;
  logic [HALF_PROD_W-1:0]  q_hl;
  logic [HALF_PROD_W-1:0]  q_lh;
  logic [HALF_PROD_W-1:0]  q_hh;
  logic [PROD_W-1:0]       llhh;
  logic [PROD_W-1:0]       lh_shifted;
  logic [PROD_W-1:0]       hl_shifted;
  logic [PROD_W-1:0]       llhh_lh;
  logic [PROD_W-1:0]       prod_next;
  logic [PIPE_LATENCY-1:0] valid_q;

  array_mult8 ll (.a(opa[HALF_W-1:0]),         .b(opb[HALF_W-1:0]),         .p(p_ll));
  array_mult8 hl (.a(opa[OPERAND_W-1:HALF_W]), .b(opb[HALF_W-1:0]),         .p(p_hl));
  array_mult8 lh (.a(opa[HALF_W-1:0]),         .b(opb[OPERAND_W-1:HALF_W]), .p(p_lh));
  array_mult8 hh (.a(opa[OPERAND_W-1:HALF_W]), .b(opb[OPERAND_W-1:HALF_W]), .p(p_hh));

  // Stage 1
  always_ff @(posedge clk) begin
    q_ll <= p_ll;
    q_hl <= p_hl;
    q_lh <= p_lh;
    q_hh <= p_hh;
  end

  // Cross terms sit one byte up
  assign llhh       = {q_hh, q_ll};
  assign lh_shifted = {{HALF_W{1'b0}}, q_lh, {HALF_W{1'b0}}};
  assign hl_shifted = {{HALF_W{1'b0}}, q_hl, {HALF_W{1'b0}}};

  cla_adder32 sum_llhh_lh (.a(llhh),    .b(lh_shifted), .sum(llhh_lh));
  cla_adder32 sum_final   (.a(llhh_lh), .b(hl_shifted), .sum(prod_next));

  // Stage 2
  always_ff @(posedge clk) begin
    prod <= prod_next;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[PIPE_LATENCY-2:0], mul_valid};
    end
  end

  assign prod_valid = valid_q[PIPE_LATENCY-1];

endmodule

`default_nettype wire

/* rtl/mult_pkg.sv */
`default_nettype none

package mult_pkg;

  localparam int OPERAND_W    = 16;
  localparam int HALF_W       = 8;
  localparam int PROD_W       = 32;
  localparam int HALF_PROD_W  = 16;

  // Cycles from mul_valid to prod_valid
  localparam int PIPE_LATENCY = 2;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    DONE = 2'd2
  } mult_state_t;

endpackage

`default_nettype wire

/* tb.f */
rtl/mult_pkg.sv
rtl/apb_pkg.sv
rtl/array_mult8.sv
rtl/cla_adder32.sv
rtl/mult16_datapath.sv
rtl/apb_mult_regs.sv
rtl/mult16_apb.sv
test/tb_mult16_apb.sv

/* test/tb_mult16_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mult16_apb;

  import mult_pkg::*;
  import apb_pkg::*;

  localparam int N_RANDOM     = 200;
  localparam int N_OPS        = N_RANDOM + 25 + 2;
  localparam int FOLLOW_READ  = 0;
  localparam int FOLLOW_START = 1;
  localparam int FOLLOW_CLEAR = 2;

  logic                  clk;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [APB_DATA_W-1:0] pwdata;
  logic [APB_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  // Expectations for the access cycle in progress
  logic                  chk_rdata;
  logic [APB_DATA_W-1:0] exp_rdata;
  logic                  exp_err;
  int                    errors;

  logic [OPERAND_W-1:0]  corners [5] = '{16'h0000, 16'h0001, 16'hffff, 16'h00ff, 16'hff00};

  mult16_apb DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #20 clk = ~clk;

  a_pready: assert property (@(posedge clk) disable iff (!rst_n)
      (psel && penable) |-> pready)
    else begin
      errors++;
      $display("mismatch at %0t: pready expected 1 got %b", $time, $sampled(pready));
    end

  a_pslverr: assert property (@(posedge clk) disable iff (!rst_n)
      pslverr == (psel && penable && exp_err))
    else begin
      errors++;
      $display("mismatch at %0t: pslverr expected %b got %b (paddr 0x%02h)", $time,
               $sampled(psel && penable && exp_err), $sampled(pslverr), $sampled(paddr));
    end

  a_prdata: assert property (@(posedge clk) disable iff (!rst_n)
      (psel && penable && !pwrite && chk_rdata) |-> (prdata == exp_rdata))
    else begin
      errors++;
      $display("mismatch at %0t: prdata expected 0x%08h got 0x%08h (paddr 0x%02h)", $time,
               $sampled(exp_rdata), $sampled(prdata), $sampled(paddr));
    end

  // Busy and done never show together, upper status bits stay zero
  a_status: assert property (@(posedge clk) disable iff (!rst_n)
      (psel && penable && !pwrite && paddr == ADDR_STATUS) |-> (prdata inside {0, 1, 2}))
    else begin
      errors++;
      $display("mismatch at %0t: prdata expected status 0, 1 or 2 got 0x%08h", $time,
               $sampled(prdata));
    end

  function automatic logic addr_mapped(input logic [APB_ADDR_W-1:0] addr);
    return addr inside {ADDR_OPA, ADDR_OPB, ADDR_CTRL, ADDR_STATUS, ADDR_RESULT};
  endfunction

  task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [APB_DATA_W-1:0] data);
    @(posedge clk);
    psel      <= 1'b1;
    penable   <= 1'b0;
    pwrite    <= 1'b1;
    paddr     <= addr;
    pwdata    <= data;
    chk_rdata <= 1'b0;
    exp_err   <= !addr_mapped(addr);
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
  endtask

  task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, input logic check,
                          input logic [APB_DATA_W-1:0] expected,
                          output logic [APB_DATA_W-1:0] rdata);
    @(posedge clk);
    psel      <= 1'b1;
    penable   <= 1'b0;
    pwrite    <= 1'b0;
    paddr     <= addr;
    chk_rdata <= check;
    exp_rdata <= expected;
    exp_err   <= !addr_mapped(addr);
    @(posedge clk);
    penable <= 1'b1;
    // Mid access cycle, away from the edges
    @(negedge clk);
    rdata = prdata;
  endtask

  task automatic apb_idle();
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic wait_done();
    logic [APB_DATA_W-1:0] rd;
    logic                  done;
    done = 1'b0;
    for (int tries = 0; tries < 16 && !done; tries++) begin
      apb_read(ADDR_STATUS, 1'b0, '0, rd);
      done = rd[STATUS_DONE_BIT];
    end
    if (!done) begin
      errors++;
      $display("Done bit never came up after 16 STATUS polls, time %0t", $time);
    end
  endtask

  task automatic run_mult(input logic [OPERAND_W-1:0] a, input logic [OPERAND_W-1:0] b,
                          input int follow);
    logic [PROD_W-1:0]     expected;
    logic [APB_DATA_W-1:0] rd;
    expected = 32'(a) * 32'(b);
    apb_write(ADDR_OPA, 32'(a));
    apb_write(ADDR_OPB, 32'(b));
    apb_write(ADDR_CTRL, 32'(CMD_START));
    // The next access still falls inside the busy window
    case (follow)
      FOLLOW_START: apb_write(ADDR_CTRL, 32'(CMD_START));
      FOLLOW_CLEAR: apb_write(ADDR_CTRL, 32'(CMD_CLEAR));
      default:      apb_read(ADDR_STATUS, 1'b1, 32'(1) << STATUS_BUSY_BIT, rd);
    endcase
    wait_done();
    apb_read(ADDR_RESULT, 1'b1, expected, rd);
    apb_read(ADDR_OPA, 1'b1, 32'(a), rd);
    apb_read(ADDR_OPB, 1'b1, 32'(b), rd);
  endtask

  initial begin : watchdog
    #((N_OPS * 20 + 200) * 40);
    $display("Timeout at %0t, stimulus did not finish, %0d errors so far", $time, errors);
    $display("Test failed");
    $finish;
  end

  initial begin : stimulus
    logic [APB_DATA_W-1:0] rd;
    logic [OPERAND_W-1:0]  a;
    logic [OPERAND_W-1:0]  b;
    void'($urandom(32'hf782_ada6));
    clk       = 1'b0;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    chk_rdata = 1'b0;
    exp_rdata = '0;
    exp_err   = 1'b0;
    errors    = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    apb_read(ADDR_STATUS, 1'b1, '0, rd);
    apb_read(ADDR_RESULT, 1'b1, '0, rd);
    apb_read(ADDR_OPA, 1'b1, '0, rd);

    foreach (corners[i]) begin
      foreach (corners[j]) begin
        run_mult(corners[i], corners[j], FOLLOW_READ);
      end
    end
    for (int n = 0; n < N_RANDOM; n++) begin
      a = 16'($urandom());
      b = 16'($urandom());
      run_mult(a, b, FOLLOW_READ);
    end

    run_mult(16'hbeef, 16'h1234, FOLLOW_START);
    run_mult(16'hffff, 16'h8001, FOLLOW_CLEAR);

    // Clear after done keeps the result
    apb_write(ADDR_CTRL, 32'(CMD_CLEAR));
    apb_read(ADDR_STATUS, 1'b1, '0, rd);
    apb_read(ADDR_RESULT, 1'b1, 32'hffff * 32'h8001, rd);

    // Read-only registers and unmapped addresses
    apb_write(ADDR_RESULT, 32'h5a5a_a5a5);
    apb_read(ADDR_RESULT, 1'b1, 32'hffff * 32'h8001, rd);
    apb_write(ADDR_STATUS, 32'h3);
    apb_read(ADDR_STATUS, 1'b1, '0, rd);
    apb_write(8'h14, 32'h1234_5678);
    apb_read(8'h14, 1'b0, '0, rd);
    apb_write(8'hfc, 32'hdead_beef);
    apb_read(8'hfc, 1'b0, '0, rd);
    apb_idle();
    apb_idle();

    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
